/* Makefile */
# Verilator build and run of the UART peripheral testbench
TOP := uart_periph_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f uart_periph.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* hdl/uart_des.sv */
// UART deserializer
// start bit check at the sample phase, then one sample per bit period
`timescale 1ns/10ps
`default_nettype none

module uart_des (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::uart_rate_t cfg_bdr,  // bit period minus 1
    input  uart_pkg::uart_rate_t cfg_smp,  // start bit sample point
    input  logic                 rxd,
    output logic                 vld,      // one clock per good frame
    output uart_pkg::uart_data_t dat
);

    logic                           rxd_s1;
    logic                           rxd_s2;   // synchronized line
    uart_pkg::des_state_t           state;
    uart_pkg::uart_rate_t           cnt;      // clocks since last sample
    logic [uart_pkg::bit_idx_w-1:0] idx;
    uart_pkg::uart_data_t           shr;
    logic                           smp_bit;  // bit period elapsed

    ////////////////////////////////////////////////////////////
    // input synchronizer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rxd_s1 <= 1'b1;
            rxd_s2 <= 1'b1;
        end else begin
            rxd_s1 <= rxd;
            rxd_s2 <= rxd_s1;
        end
    end

    ////////////////////////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////////////////////////

    assign smp_bit = (cnt == cfg_bdr);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= uart_pkg::des_idle;
            cnt   <= '0;
            idx   <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                uart_pkg::des_idle: begin
                    cnt <= '0;
                    if (!rxd_s2) state <= uart_pkg::des_start;  // falling edge
                end
                uart_pkg::des_start: if (cnt == cfg_smp) begin
                    cnt   <= '0;
                    idx   <= '0;
                    // glitch goes back to idle
                    state <= rxd_s2 ? uart_pkg::des_idle : uart_pkg::des_data;
                end
                uart_pkg::des_data: if (smp_bit) begin
                    cnt <= '0;
                    idx <= idx + 1'b1;
                    if (idx == '1) state <= uart_pkg::des_stop;
                end
                uart_pkg::des_stop: if (smp_bit) begin
                    state <= uart_pkg::des_idle;  // low stop bit just drops the byte
                end
                default: state <= uart_pkg::des_idle;
            endcase
        end
    end

    // LSB arrives first, shift towards bit 0
    always_ff @(posedge clk) begin
        if ((state == uart_pkg::des_data) && smp_bit) shr <= {rxd_s2, shr[7:1]};
    end

    assign vld = (state == uart_pkg::des_stop) && smp_bit && rxd_s2;
    assign dat = shr;

    assert property (@(posedge clk) disable iff (rst)
        vld |=> !vld)
        else $error("deserializer vld held two cycles");

endmodule

`default_nettype wire

/* hdl/uart_fifo.sv */
// synchronous character FIFO with valid/ready on both sides
// occupancy count output for status and interrupts
`timescale 1ns/10ps
`default_nettype none

module uart_fifo (
    input  logic                 clk,
    input  logic                 rst,
    // write side
    input  logic                 in_vld,
    input  uart_pkg::uart_data_t in_dat,
    output logic                 in_rdy,   // not full
    // read side
    output logic                 out_vld,  // not empty
    output uart_pkg::uart_data_t out_dat,  // head entry
    input  logic                 out_rdy,
    // status
    output uart_pkg::fifo_cnt_t  cnt
);

    uart_pkg::uart_data_t mem [uart_pkg::fifo_depth];
    logic [uart_pkg::fifo_adr_w-1:0] wr_ptr;  // wraps at depth
    logic [uart_pkg::fifo_adr_w-1:0] rd_ptr;
    logic push;
    logic pop;

    assign in_rdy  = (cnt != uart_pkg::fifo_cnt_t'(uart_pkg::fifo_depth));
    assign out_vld = (cnt != '0);
    assign out_dat = mem[rd_ptr];

    assign push = in_vld & in_rdy;
    assign pop  = out_vld & out_rdy;  // read strobe on empty is harmless

    ////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;        // idle or push+pop
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_dat;
    end

    // occupancy bounded by depth
    assert property (@(posedge clk) disable iff (rst)
        cnt <= uart_pkg::fifo_cnt_t'(uart_pkg::fifo_depth))
        else $error("fifo count above depth");

    // pointers meet whenever the FIFO is empty
    assert property (@(posedge clk) disable iff (rst)
        (cnt == '0) |-> (rd_ptr == wr_ptr))
        else $error("fifo pointers apart while empty");

endmodule

`default_nettype wire

/* hdl/uart_periph.sv */
// UART peripheral top on a single-cycle register bus
// register decode, config registers, TX and RX channels, interrupts
`timescale 1ns/10ps
`default_nettype none

module uart_periph (
    input  logic                clk,
    input  logic                rst,
    // write bus
    input  logic                wen,
    input  uart_pkg::bus_addr_t wad,
    input  uart_pkg::bus_data_t wdt,
    // read bus
    input  logic                ren,
    input  uart_pkg::bus_addr_t rad,
    output uart_pkg::bus_data_t rdt,
    // serial line
    input  logic                rxd,
    output logic                txd,
    // interrupts
    output logic                irq_tx,  // TX FIFO below watermark
    output logic                irq_rx   // RX FIFO above watermark
);

    uart_pkg::uart_cfg_t  cfg;
    // bus side of the FIFOs
    logic                 tx_bus_vld, tx_bus_rdy;
    logic                 rx_bus_vld, rx_bus_rdy;
    uart_pkg::uart_data_t rx_bus_dat;
    // serial side of the FIFOs
    logic                 tx_str_vld, tx_str_rdy;
    logic                 rx_str_vld;
    uart_pkg::uart_data_t tx_str_dat, rx_str_dat;
    uart_pkg::fifo_cnt_t  tx_cnt, rx_cnt;

    ////////////////////////////////////////////////////////////
    // register writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cfg <= uart_pkg::cfg_rst;
        end else if (wen) begin
            case (wad)
                uart_pkg::adr_tx_bdr: cfg.tx_bdr <= wdt[uart_pkg::rate_w-1:0];
                uart_pkg::adr_tx_irq: cfg.tx_irq <= wdt[uart_pkg::fifo_cnt_w-1:0];
                uart_pkg::adr_rx_bdr: cfg.rx_bdr <= wdt[uart_pkg::rate_w-1:0];
                uart_pkg::adr_rx_smp: cfg.rx_smp <= wdt[uart_pkg::rate_w-1:0];
                uart_pkg::adr_rx_irq: cfg.rx_irq <= wdt[uart_pkg::fifo_cnt_w-1:0];
                default: ;  // data and counts handled elsewhere
            endcase
        end
    end

    assign tx_bus_vld = wen && (wad == uart_pkg::adr_tx_data);  // dropped when full

    ////////////////////////////////////////////////////////////
    // register reads
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (rad)
            uart_pkg::adr_tx_cnt:  rdt = uart_pkg::bus_data_t'(tx_cnt);
            uart_pkg::adr_tx_bdr:  rdt = uart_pkg::bus_data_t'(cfg.tx_bdr);
            uart_pkg::adr_tx_irq:  rdt = uart_pkg::bus_data_t'(cfg.tx_irq);
            uart_pkg::adr_rx_data: rdt = rx_bus_vld ? uart_pkg::bus_data_t'(rx_bus_dat) : '0;
            uart_pkg::adr_rx_cnt:  rdt = uart_pkg::bus_data_t'(rx_cnt);
            uart_pkg::adr_rx_bdr:  rdt = uart_pkg::bus_data_t'(cfg.rx_bdr);
            uart_pkg::adr_rx_smp:  rdt = uart_pkg::bus_data_t'(cfg.rx_smp);
            uart_pkg::adr_rx_irq:  rdt = uart_pkg::bus_data_t'(cfg.rx_irq);
            default:               rdt = '0;  // incl. TX data
        endcase
    end

    assign rx_bus_rdy = ren && (rad == uart_pkg::adr_rx_data);  // pop on read

    ////////////////////////////////////////////////////////////
    // channels
    ////////////////////////////////////////////////////////////

    uart_fifo tx_fifo (
        .clk (clk), .rst (rst),
        .in_vld  (tx_bus_vld), .in_dat (wdt[uart_pkg::data_w-1:0]), .in_rdy (tx_bus_rdy),
        .out_vld (tx_str_vld), .out_dat (tx_str_dat), .out_rdy (tx_str_rdy),
        .cnt     (tx_cnt)
    );

    uart_ser tx_ser (
        .clk (clk), .rst (rst), .cfg_bdr (cfg.tx_bdr),
        .vld (tx_str_vld), .dat (tx_str_dat), .rdy (tx_str_rdy), .txd (txd)
    );

    uart_fifo rx_fifo (
        .clk (clk), .rst (rst),
        .in_vld  (rx_str_vld), .in_dat (rx_str_dat), .in_rdy (),  // full drops bytes
        .out_vld (rx_bus_vld), .out_dat (rx_bus_dat), .out_rdy (rx_bus_rdy),
        .cnt     (rx_cnt)
    );

    uart_des rx_des (
        .clk (clk), .rst (rst), .cfg_bdr (cfg.rx_bdr), .cfg_smp (cfg.rx_smp),
        .rxd (rxd), .vld (rx_str_vld), .dat (rx_str_dat)
    );

    assign irq_tx = (tx_cnt < cfg.tx_irq);
    assign irq_rx = (rx_cnt > cfg.rx_irq);

    // accepted bus write lands in the TX count
    assert property (@(posedge clk) disable iff (rst)
        tx_bus_vld && tx_bus_rdy && !(tx_str_vld && tx_str_rdy)
        |=> tx_cnt == $past(tx_cnt) + 1'b1)
        else $error("TX count missed a bus write");

    // bus read of a non-empty RX FIFO drops the count by one
    assert property (@(posedge clk) disable iff (rst)
        rx_bus_rdy && rx_bus_vld && !rx_str_vld
        |=> rx_cnt == $past(rx_cnt) - 1'b1)
        else $error("RX count missed a bus read");

endmodule

`default_nettype wire

/* hdl/uart_pkg.sv */
// shared widths, vector types and register map of the UART peripheral
// configuration struct and FSM state encodings
`default_nettype none

package uart_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int data_w     = 8;                  // one character
    localparam int bit_idx_w  = $clog2(data_w);     // data bit index
    localparam int rate_w     = 8;                  // baud and sample counters
    localparam int fifo_depth = 16;
    localparam int fifo_adr_w = $clog2(fifo_depth); // FIFO pointer
    localparam int fifo_cnt_w = 5;                  // 0 to 16
    localparam int bus_addr_w = 4;
    localparam int bus_data_w = 32;

    typedef logic [data_w-1:0]     uart_data_t;
    typedef logic [rate_w-1:0]     uart_rate_t;     // bit period minus 1
    typedef logic [fifo_cnt_w-1:0] fifo_cnt_t;
    typedef logic [bus_addr_w-1:0] bus_addr_t;
    typedef logic [bus_data_w-1:0] bus_data_t;

    ////////////////////////////////////////////////////////////
    // register map
    ////////////////////////////////////////////////////////////

    localparam bus_addr_t adr_tx_data = 4'd0;   // push TX FIFO
    localparam bus_addr_t adr_tx_cnt  = 4'd1;   // TX occupancy, read only
    localparam bus_addr_t adr_tx_bdr  = 4'd2;
    localparam bus_addr_t adr_tx_irq  = 4'd4;   // TX low watermark
    localparam bus_addr_t adr_rx_data = 4'd8;   // pop RX FIFO
    localparam bus_addr_t adr_rx_cnt  = 4'd9;
    localparam bus_addr_t adr_rx_bdr  = 4'd10;
    localparam bus_addr_t adr_rx_smp  = 4'd11;  // start bit sample phase
    localparam bus_addr_t adr_rx_irq  = 4'd12;  // RX high watermark

    typedef struct packed {
        uart_rate_t tx_bdr;
        uart_rate_t rx_bdr;
        uart_rate_t rx_smp;
        fifo_cnt_t  tx_irq;
        fifo_cnt_t  rx_irq;
    } uart_cfg_t;

    localparam uart_cfg_t cfg_rst = '0;

    typedef enum logic [1:0] {ser_idle, ser_start, ser_data, ser_stop} ser_state_t;
    typedef enum logic [1:0] {des_idle, des_start, des_data, des_stop} des_state_t;

endpackage

`default_nettype wire

/* hdl/uart_ser.sv */
// UART serializer
// 1 start bit, 8 data bits LSB first, 1 stop bit
`timescale 1ns/10ps
`default_nettype none

module uart_ser (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::uart_rate_t cfg_bdr,  // bit period minus 1
    input  logic                 vld,
    input  uart_pkg::uart_data_t dat,
    output logic                 rdy,
    output logic                 txd
);

    uart_pkg::ser_state_t            state;
    uart_pkg::uart_rate_t            cnt;    // counts down to bit end
    logic [uart_pkg::bit_idx_w-1:0]  idx;    // data bit on the line
    uart_pkg::uart_data_t            shr;    // next bit in shr[0]
    logic                            bit_end;

    assign rdy     = (state == uart_pkg::ser_idle);
    assign bit_end = (cnt == '0);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= uart_pkg::ser_idle;
            cnt   <= '0;
            idx   <= '0;
            txd   <= 1'b1;  // idle line
        end else begin
            case (state)
                uart_pkg::ser_idle: if (vld) begin
                    state <= uart_pkg::ser_start;
                    cnt   <= cfg_bdr;
                    txd   <= 1'b0;              // start bit
                end
                uart_pkg::ser_start: if (bit_end) begin
                    state <= uart_pkg::ser_data;
                    cnt   <= cfg_bdr;
                    idx   <= '0;
                    txd   <= shr[0];            // bit 0
                end else cnt <= cnt - 1'b1;
                uart_pkg::ser_data: if (bit_end) begin
                    cnt <= cfg_bdr;
                    if (idx == '1) begin
                        state <= uart_pkg::ser_stop;
                        txd   <= 1'b1;          // stop bit
                    end else begin
                        idx <= idx + 1'b1;
                        txd <= shr[0];
                    end
                end else cnt <= cnt - 1'b1;
                // leave one clock early, idle cycle completes the stop bit
                uart_pkg::ser_stop: if (cnt <= uart_pkg::uart_rate_t'(1)) begin
                    state <= uart_pkg::ser_idle;
                end else cnt <= cnt - 1'b1;
                default: state <= uart_pkg::ser_idle;
            endcase
        end
    end

    // shift register, loaded on accept
    always_ff @(posedge clk) begin
        if (rdy && vld) shr <= dat;
        else if (bit_end && (state != uart_pkg::ser_idle) && (state != uart_pkg::ser_stop))
            shr <= shr >> 1;
    end

    assert property (@(posedge clk) disable iff (rst)
        (state == uart_pkg::ser_idle) |-> txd)
        else $error("txd low while serializer idle");

endmodule

`default_nettype wire

/* uart_periph.f */
hdl/uart_pkg.sv
hdl/uart_fifo.sv
hdl/uart_ser.sv
hdl/uart_des.sv
hdl/uart_periph.sv
verif/uart_periph_tb.sv

/* verif/uart_periph_tb.sv */
// UART peripheral testbench
// bus tasks, serial loopback with bad frame injection, checking assertions
`timescale 1ns/10ps
`default_nettype none

module uart_periph_tb;

    localparam int max_cycles = 40000;
    localparam int loop_clks  = 10;                  // loopback bit period

    logic clk = 1'b0;
    logic rst, wen, ren, txd, irq_tx, irq_rx;
    logic loop_on, inj_bit;                          // rxd source select
    wire  rxd;
    uart_pkg::bus_addr_t  wad, rad;
    uart_pkg::bus_data_t  wdt, rdt;
    uart_pkg::bus_data_t  tx_irq_cfg, rx_irq_cfg;    // shadow thresholds
    uart_pkg::uart_data_t exp_q[$];                  // bytes in flight
    integer seed = 32'ha322;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    logic txd_n, txd_p;                              // txd seen at falling edges
    int run_n, run_p;                                // high clocks before them

    always #50 clk = ~clk;

    assign rxd = loop_on ? txd : inj_bit;            // loopback or injected frame

    uart_periph i_uart_periph (
        .clk (clk), .rst (rst), .wen (wen), .wad (wad), .wdt (wdt),
        .ren (ren), .rad (rad), .rdt (rdt), .rxd (rxd), .txd (txd),
        .irq_tx (irq_tx), .irq_rx (irq_rx)
    );

    ////////////////////////////////////////////////////////////
    // checking assertions
    ////////////////////////////////////////////////////////////

    // line run lengths, stable by the next rising edge
    always @(negedge clk) begin
        txd_n <= txd;
        txd_p <= txd_n;
        run_n <= txd ? run_n + 1 : 0;
        run_p <= run_n;
    end

    // reset leaves the line idle and both interrupts low
    assert property (@(posedge clk) $fell(rst) |-> txd && !irq_tx && !irq_rx)
    else begin
        errors++;
        $display("txd low or an interrupt high right after reset");
    end

    // every high stretch on the line lasts whole bit periods
    assert property (@(posedge clk) disable iff (rst || !loop_on)
        (txd_p && !txd_n) |-> run_p >= loop_clks)
    else begin
        errors++;
        $display("txd high for only %0d clocks before falling", run_p);
    end

    ////////////////////////////////////////////////////////////
    // bus and line tasks
    ////////////////////////////////////////////////////////////

    task automatic compare(input string name, input uart_pkg::bus_data_t exp,
                           input uart_pkg::bus_data_t act);
        checks++;
        assert (act === exp)
        else begin
            errors++;
            $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic write_reg(input uart_pkg::bus_addr_t addr, input uart_pkg::bus_data_t data);
        wen = 1'b1;
        wad = addr;
        wdt = data;
        @(posedge clk);
        #10;
        wen = 1'b0;
        if (addr == uart_pkg::adr_tx_irq)
            tx_irq_cfg = data & 32'h1f;              // 5 bit field
        if (addr == uart_pkg::adr_rx_irq)
            rx_irq_cfg = data & 32'h1f;
    endtask

    // rdt sampled late in the cycle, pop on the following edge
    task automatic read_reg(input uart_pkg::bus_addr_t addr, input logic pop,
                            output uart_pkg::bus_data_t val);
        rad = addr;
        ren = pop;
        #30;
        val = rdt;
        if (addr == uart_pkg::adr_tx_cnt)            // irq_tx while count below threshold
            compare("irq_tx level", uart_pkg::bus_data_t'(val < tx_irq_cfg),
                    uart_pkg::bus_data_t'(irq_tx));
        if (addr == uart_pkg::adr_rx_cnt)            // irq_rx while count above threshold
            compare("irq_rx level", uart_pkg::bus_data_t'(val > rx_irq_cfg),
                    uart_pkg::bus_data_t'(irq_rx));
        @(posedge clk);
        #10;
        ren = 1'b0;
    endtask

    task automatic expect_reg(input string name, input uart_pkg::bus_addr_t addr,
                              input uart_pkg::bus_data_t exp);
        uart_pkg::bus_data_t val;
        read_reg(addr, 1'b0, val);
        compare(name, exp, val);
    endtask

    task automatic wait_count(input uart_pkg::bus_addr_t addr, input uart_pkg::bus_data_t target);
        uart_pkg::bus_data_t val;
        do begin
            read_reg(addr, 1'b0, val);
        end while (val != target);
    endtask

    // txd high for a number of clocks in a row
    task automatic settle_line(input int clks);
        int n;
        n = 0;
        while (n < clks) begin
            n = txd ? n + 1 : 0;
            @(posedge clk);
            #10;
        end
    endtask

    task automatic send_bytes(input int n);
        uart_pkg::uart_data_t b;
        for (int i = 0; i < n; i++) begin
            b = uart_pkg::uart_data_t'($random(seed));
            exp_q.push_back(b);
            write_reg(uart_pkg::adr_tx_data, uart_pkg::bus_data_t'(b));
        end
    endtask

    task automatic drain_rx(input int n);
        uart_pkg::bus_data_t val;
        uart_pkg::uart_data_t b;
        for (int i = 0; i < n; i++) begin
            b = exp_q.pop_front();
            read_reg(uart_pkg::adr_rx_data, 1'b1, val);
            compare("loopback byte", uart_pkg::bus_data_t'(b), val);
            expect_reg("rx_cnt after pop", uart_pkg::adr_rx_cnt, n - 1 - i);
        end
    endtask

    task automatic inject_frame(input uart_pkg::uart_data_t data, input logic stop);
        logic [9:0] frame;
        frame = {stop, data, 1'b0};                  // start bit goes out first
        for (int i = 0; i < 10; i++) begin
            inj_bit = frame[i];
            repeat (loop_clks) @(posedge clk);
            #10;
        end
        inj_bit = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        uart_pkg::bus_data_t val;
        rst        = 1'b1;
        wen        = 1'b0;
        wad        = '0;
        wdt        = '0;
        ren        = 1'b0;
        rad        = '0;
        loop_on    = 1'b0;
        inj_bit    = 1'b1;                           // idle injection line
        tx_irq_cfg = '0;
        rx_irq_cfg = '0;
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;

        // reset values
        expect_reg("reset tx_cnt", uart_pkg::adr_tx_cnt, 0);
        expect_reg("reset tx_bdr", uart_pkg::adr_tx_bdr, 0);
        expect_reg("reset tx_irq", uart_pkg::adr_tx_irq, 0);
        expect_reg("reset rx_cnt", uart_pkg::adr_rx_cnt, 0);
        expect_reg("reset rx_bdr", uart_pkg::adr_rx_bdr, 0);
        expect_reg("reset rx_smp", uart_pkg::adr_rx_smp, 0);
        expect_reg("reset rx_irq", uart_pkg::adr_rx_irq, 0);
        expect_reg("unmapped 3", 4'd3, 0);
        expect_reg("unmapped 15", 4'd15, 0);
        read_reg(uart_pkg::adr_rx_data, 1'b1, val);  // pop strobe on empty FIFO
        compare("empty rx_data", 0, val);

        // config readback, fields zero-extended
        write_reg(uart_pkg::adr_tx_bdr, 32'h0000_0013);
        write_reg(uart_pkg::adr_tx_bdr, 32'habcd_ef5a);
        write_reg(uart_pkg::adr_tx_irq, 32'hffff_ffe9);
        write_reg(uart_pkg::adr_rx_bdr, 32'h1234_56c3);
        write_reg(uart_pkg::adr_rx_smp, 32'h0000_0177);
        write_reg(uart_pkg::adr_rx_irq, 32'h0000_003f);
        write_reg(uart_pkg::adr_tx_cnt, 32'h0000_0005);  // read only
        expect_reg("cfg tx_bdr", uart_pkg::adr_tx_bdr, 32'h5a);
        expect_reg("cfg tx_irq", uart_pkg::adr_tx_irq, 32'h09);
        expect_reg("cfg rx_bdr", uart_pkg::adr_rx_bdr, 32'hc3);
        expect_reg("cfg rx_smp", uart_pkg::adr_rx_smp, 32'h77);
        expect_reg("cfg rx_irq", uart_pkg::adr_rx_irq, 32'h1f);
        expect_reg("tx_cnt after write", uart_pkg::adr_tx_cnt, 0);

        // slow TX drain, irq_tx below 4, FIFO bound
        write_reg(uart_pkg::adr_tx_bdr, 49);         // 50 clock bits
        write_reg(uart_pkg::adr_tx_irq, 4);
        expect_reg("tx_cnt idle", uart_pkg::adr_tx_cnt, 0);
        write_reg(uart_pkg::adr_tx_data, $random(seed));  // serializer busy first
        wait_count(uart_pkg::adr_tx_cnt, 0);
        for (int i = 0; i < 17; i++)
            write_reg(uart_pkg::adr_tx_data, $random(seed));
        expect_reg("tx_cnt full", uart_pkg::adr_tx_cnt, 16);  // last write dropped
        wait_count(uart_pkg::adr_tx_cnt, 0);         // irq_tx compared on each poll
        settle_line(10 * 50);                        // longer than any high run of a slow frame

        // loopback of 8 random bytes
        write_reg(uart_pkg::adr_tx_bdr, loop_clks - 1);
        write_reg(uart_pkg::adr_rx_bdr, loop_clks - 1);
        write_reg(uart_pkg::adr_rx_smp, 4);
        loop_on = 1'b1;
        send_bytes(8);
        wait_count(uart_pkg::adr_rx_cnt, 8);
        drain_rx(8);

        // irq_rx above 2, then a frame with a low stop bit
        write_reg(uart_pkg::adr_rx_irq, 2);
        send_bytes(4);
        for (int k = 1; k <= 4; k++)
            wait_count(uart_pkg::adr_rx_cnt, k);
        compare("irq_rx with 4 bytes", 1, uart_pkg::bus_data_t'(irq_rx));
        settle_line(2 * loop_clks);
        loop_on = 1'b0;
        inject_frame(8'ha5, 1'b0);
        repeat (2 * loop_clks) @(posedge clk);     // deserializer back in idle
        #10;
        expect_reg("rx_cnt after bad stop", uart_pkg::adr_rx_cnt, 4);
        loop_on = 1'b1;
        drain_rx(4);
        compare("irq_rx drained", 0, uart_pkg::bus_data_t'(irq_rx));

        $display("errors %0d, checks %0d", errors, checks);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // run limit
    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, errors %0d, checks %0d", cycles, errors, checks);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
